//--- source/soc_bus_defs.svh
`ifndef SOC_BUS_DEFS_SVH
`define SOC_BUS_DEFS_SVH

// address map, compared against adr[31:16]
`define SOC_RAM_BASE_HI   16'h0000
`define SOC_TEXT_BASE_HI  16'hFFD0

// memory sizes in words
`define SOC_RAM_DEPTH     2048 // 64-bit words, 16 KiB
`define SOC_TEXT_DEPTH    2048 // 32-bit words, 8 KiB

// byte lanes per word on each bus
`define SOC_SYS_LANES     8
`define SOC_IO_LANES      4

// address bit that picks the 32-bit half
`define SOC_HALF_BIT      2

`endif

//--- source/soc_bus_pkg.sv
package soc_bus_pkg;

	typedef logic [31:0] adr_t; // byte address
	typedef logic [63:0] dat64_t; // system data word
	typedef logic [31:0] dat32_t; // i/o data word
	typedef logic [7:0]  sel8_t; // system byte enables
	typedef logic [3:0]  sel4_t; // i/o byte enables

	// system bus, master to slave
	typedef struct packed {
		logic   cyc;
		logic   stb;
		logic   we;
		sel8_t  sel;
		adr_t   adr;
		dat64_t dat;
	} bus_req_t;

	// system bus, slave to master
	typedef struct packed {
		logic   ack;
		logic   err;
		dat64_t dat;
	} bus_rsp_t;

	// i/o bus, bridge to slave
	typedef struct packed {
		logic   cyc;
		logic   stb;
		logic   we;
		sel4_t  sel;
		adr_t   adr;
		dat32_t dat;
	} io_req_t;

	// i/o bus, slave to bridge
	typedef struct packed {
		logic   ack;
		dat32_t dat;
	} io_rsp_t;

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		DONE
	} bridge_state_e;

endpackage

//--- source/bus_decoder.sv
`include "soc_bus_defs.svh"

module bus_decoder import soc_bus_pkg::*; (
	input  logic     clk,
	input  logic     arst_n_i,
	input  bus_req_t req_i,
	output bus_rsp_t rsp_o,
	output bus_req_t ram_req_o,
	input  bus_rsp_t ram_rsp_i,
	output bus_req_t io_req_o,
	input  bus_rsp_t io_rsp_i
);

	logic ram_hit;
	logic io_hit;
	logic unmapped;
	logic err_q;

	assign ram_hit  = (req_i.adr[31:16] == `SOC_RAM_BASE_HI);
	assign io_hit   = (req_i.adr[31:16] == `SOC_TEXT_BASE_HI);
	assign unmapped = !ram_hit && !io_hit;

	// targets see the full request, stb only where it decodes
	always_comb begin
		ram_req_o     = req_i;
		ram_req_o.stb = req_i.stb & ram_hit;
		io_req_o      = req_i;
		io_req_o.stb  = req_i.stb & io_hit;
	end

	// one-cycle error pulse for a hole in the map
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			err_q <= 1'b0;
		end else begin
			err_q <= req_i.cyc & req_i.stb & unmapped & ~err_q;
		end
	end

	always_comb begin
		rsp_o.ack = ram_rsp_i.ack | io_rsp_i.ack;
		rsp_o.err = err_q | ram_rsp_i.err | io_rsp_i.err;
		if (io_rsp_i.ack) begin
			rsp_o.dat = io_rsp_i.dat;
		end else begin
			rsp_o.dat = ram_rsp_i.dat; // default path, also idle value
		end
	end

	// a transfer ends either with ack or with err, never both
	a_ack_err_excl: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		!(rsp_o.ack && rsp_o.err)
	);

endmodule

//--- source/bus_ram.sv
`include "soc_bus_defs.svh"

module bus_ram import soc_bus_pkg::*; (
	input  logic     clk,
	input  logic     arst_n_i,
	input  bus_req_t req_i,
	output bus_rsp_t rsp_o
);

	localparam int unsigned IDX_W = $clog2(`SOC_RAM_DEPTH);

	dat64_t mem [`SOC_RAM_DEPTH];
	dat64_t rdat_q;
	logic   ack_q;
	logic   access;
	logic   [IDX_W-1:0] idx;

	assign access = req_i.cyc & req_i.stb & ~ack_q; // once per transfer
	assign idx    = req_i.adr[IDX_W+2:3]; // word index, adr[13:3]

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// byte-lane writes, read data taken before the write lands
	always_ff @(posedge clk) begin
		if (access) begin
			rdat_q <= mem[idx];
			if (req_i.we) begin
				for (int i = 0; i < `SOC_SYS_LANES; i++) begin
					if (req_i.sel[i]) begin
						mem[idx][8*i +: 8] <= req_i.dat[8*i +: 8];
					end
				end
			end
		end
	end

	always_comb begin
		rsp_o.ack = ack_q;
		rsp_o.err = 1'b0; // every address in range is backed
		rsp_o.dat = rdat_q;
	end

	// ack only answers a strobe that the master still holds
	a_ack_after_stb: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		rsp_o.ack |-> (req_i.cyc && req_i.stb)
	);

endmodule

//--- source/io_bridge.sv
`include "soc_bus_defs.svh"

module io_bridge import soc_bus_pkg::*; (
	input  logic     clk,
	input  logic     arst_n_i,
	input  bus_req_t s_req_i,
	output bus_rsp_t s_rsp_o,
	output io_req_t  m_req_o,
	input  io_rsp_t  m_rsp_i
);

	bridge_state_e state_q;
	bridge_state_e state_d;

	logic   start;
	logic   hi_half;
	adr_t   adr_q;
	logic   we_q;
	sel4_t  sel_q;
	dat32_t wdat_q;
	dat32_t rdat_q;

	assign start   = s_req_i.cyc & s_req_i.stb;
	assign hi_half = s_req_i.adr[`SOC_HALF_BIT];

	always_comb begin
		state_d = state_q;
		case (state_q)
			IDLE: begin
				if (start) begin
					state_d = ISSUE;
				end
			end
			ISSUE: begin
				if (m_rsp_i.ack) begin
					state_d = DONE; // wait states come from the i/o slave
				end
			end
			DONE: begin
				state_d = IDLE;
			end
			default: begin
				state_d = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// narrow the request to the addressed half
	always_ff @(posedge clk) begin
		if (state_q == IDLE && start) begin
			adr_q  <= s_req_i.adr;
			we_q   <= s_req_i.we;
			sel_q  <= hi_half ? s_req_i.sel[7:4] : s_req_i.sel[3:0];
			wdat_q <= hi_half ? s_req_i.dat[63:32] : s_req_i.dat[31:0];
		end
		if (state_q == ISSUE && m_rsp_i.ack) begin
			rdat_q <= m_rsp_i.dat;
		end
	end

	always_comb begin
		m_req_o.cyc = (state_q == ISSUE);
		m_req_o.stb = (state_q == ISSUE);
		m_req_o.we  = we_q;
		m_req_o.sel = sel_q;
		m_req_o.adr = adr_q;
		m_req_o.dat = wdat_q;
	end

	always_comb begin
		s_rsp_o.ack = (state_q == DONE);
		s_rsp_o.err = 1'b0;
		s_rsp_o.dat = {2{rdat_q}}; // same word on both halves
	end

	// i/o request keeps matching the held system request
	a_io_req_stable: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		m_req_o.stb |-> (s_req_i.stb && s_req_i.adr == m_req_o.adr
			&& s_req_i.we == m_req_o.we)
	);

	a_sys_ack_held: assert property (
		@(posedge clk) disable iff (!arst_n_i)
		s_rsp_o.ack |-> (s_req_i.cyc && s_req_i.stb)
	);

endmodule

//--- source/text_mem.sv
`include "soc_bus_defs.svh"

module text_mem import soc_bus_pkg::*; (
	input  logic    clk,
	input  logic    arst_n_i,
	input  io_req_t req_i,
	output io_rsp_t rsp_o
);

	localparam int unsigned IDX_W = $clog2(`SOC_TEXT_DEPTH);

	dat32_t mem [`SOC_TEXT_DEPTH];
	dat32_t rdat_q;
	logic   ack_q;
	logic   access;
	logic   [IDX_W-1:0] idx;

	assign access = req_i.cyc & req_i.stb & ~ack_q;
	assign idx    = req_i.adr[IDX_W+1:2]; // adr[12:2]

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// char/attribute bytes written lane by lane
	always_ff @(posedge clk) begin
		if (access) begin
			rdat_q <= mem[idx];
			if (req_i.we) begin
				for (int i = 0; i < `SOC_IO_LANES; i++) begin
					if (req_i.sel[i]) begin
						mem[idx][8*i +: 8] <= req_i.dat[8*i +: 8];
					end
				end
			end
		end
	end

	always_comb begin
		rsp_o.ack = ack_q;
		rsp_o.dat = rdat_q;
	end

endmodule

//--- source/soc_bus_top.sv
module soc_bus_top import soc_bus_pkg::*; (
	input  logic     clk,
	input  logic     arst_n_i,
	input  bus_req_t req_i,
	output bus_rsp_t rsp_o
);

	bus_req_t ram_req;
	bus_rsp_t ram_rsp;
	bus_req_t brg_req;
	bus_rsp_t brg_rsp;
	io_req_t  txt_req;
	io_rsp_t  txt_rsp;

	bus_decoder decoder_i (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.req_i     (req_i),
		.rsp_o     (rsp_o),
		.ram_req_o (ram_req),
		.ram_rsp_i (ram_rsp),
		.io_req_o  (brg_req),
		.io_rsp_i  (brg_rsp)
	);

	bus_ram ram_i (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.req_i    (ram_req),
		.rsp_o    (ram_rsp)
	);

	io_bridge bridge_i (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.s_req_i  (brg_req),
		.s_rsp_o  (brg_rsp),
		.m_req_o  (txt_req),
		.m_rsp_i  (txt_rsp)
	);

	text_mem text_i (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.req_i    (txt_req),
		.rsp_o    (txt_rsp)
	);

endmodule

//--- dv/soc_bus_tb.sv
`include "soc_bus_defs.svh"

module soc_bus_tb import soc_bus_pkg::*; ();

	logic     clk;
	logic     arst_n_i;
	bus_req_t req;
	bus_rsp_t rsp;

	dat64_t ram_ref [`SOC_RAM_DEPTH];
	dat32_t text_ref [`SOC_TEXT_DEPTH];
	string  name_q[$];
	dat64_t exp_q[$];
	dat64_t act_q[$];
	int     n_pass = 0;
	int     n_fail = 0;

	soc_bus_top dut_i (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.req_i    (req),
		.rsp_o    (rsp)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// returns {err, read data}, memories updated as the bus would
	function automatic logic [64:0] ref_access(logic we, sel8_t sel, adr_t adr, dat64_t dat);
		logic [10:0] idx;
		sel4_t       s4;
		dat32_t      d32;
		dat64_t      old;
		if (adr[31:16] == `SOC_RAM_BASE_HI) begin
			idx = adr[13:3];
			old = ram_ref[idx];
			for (int i = 0; i < 8; i++) begin
				if (we && sel[i]) begin
					ram_ref[idx][8*i +: 8] = dat[8*i +: 8];
				end
			end
			return {1'b0, old};
		end
		if (adr[31:16] == `SOC_TEXT_BASE_HI) begin
			idx = adr[12:2];
			s4  = adr[2] ? sel[7:4] : sel[3:0]; // upper half on bit 2
			d32 = adr[2] ? dat[63:32] : dat[31:0];
			old = {2{text_ref[idx]}};
			for (int i = 0; i < 4; i++) begin
				if (we && s4[i]) begin
					text_ref[idx][8*i +: 8] = d32[8*i +: 8];
				end
			end
			return {1'b0, old};
		end
		return {1'b1, 64'h0}; // hole in the map
	endfunction

	function automatic adr_t ram_adr(int w);
		return {`SOC_RAM_BASE_HI, 16'((w << 3) | $urandom_range(0, 7))};
	endfunction

	function automatic adr_t text_adr(int w);
		return {`SOC_TEXT_BASE_HI, 16'((w << 2) | $urandom_range(0, 3))};
	endfunction

	task automatic check_value(string name, dat64_t exp, dat64_t act);
		if (act !== exp) begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			n_fail++;
		end else begin
			n_pass++;
		end
	endtask

	task automatic expect_value(string name, dat64_t exp, dat64_t act);
		name_q.push_back(name);
		exp_q.push_back(exp);
		act_q.push_back(act);
	endtask

	// compare process
	initial begin
		forever begin
			@(posedge clk);
			while (act_q.size() > 0) begin
				check_value(name_q.pop_front(), exp_q.pop_front(), act_q.pop_front());
			end
		end
	end

	task automatic run_transfer(string name, logic we, sel8_t sel, adr_t adr, dat64_t dat);
		logic [64:0] e;
		int          cnt;
		cnt = 0;
		e = ref_access(we, sel, adr, dat);
		@(negedge clk);
		req = '{cyc: 1'b1, stb: 1'b1, we: we, sel: sel, adr: adr, dat: dat};
		do begin
			@(negedge clk);
			cnt++;
		end while (!(rsp.ack || rsp.err) && cnt < 50);
		if (!(rsp.ack || rsp.err)) begin
			$display("%s: no response came within 50 cycles at address %h", name, adr);
			n_fail++;
			req = '0;
		end else begin
			expect_value({name, " err"}, {63'b0, e[64]}, {63'b0, rsp.err});
			expect_value({name, " ack"}, {63'b0, !e[64]}, {63'b0, rsp.ack});
			if (!we && !e[64]) begin
				expect_value({name, " data"}, e[63:0], rsp.dat);
			end
			@(negedge clk); // held across the edge that sees the response
			expect_value({name, " pulse"}, 64'd0, {62'b0, rsp.ack, rsp.err});
			req = '0;
		end
	endtask

	task automatic bus_write(string name, sel8_t sel, adr_t adr, dat64_t dat);
		run_transfer(name, 1'b1, sel, adr, dat);
	endtask

	task automatic bus_read(string name, adr_t adr);
		run_transfer(name, 1'b0, 8'hff, adr, 64'h0);
	endtask

	task automatic end_test(string name, int fails_before);
		int cnt;
		cnt = 0;
		while (act_q.size() > 0 && cnt < 10) begin
			@(negedge clk);
			cnt++;
		end
		if (act_q.size() > 0) begin
			$display("%s: pending compares were never processed", name);
			n_fail++;
		end
		$display("%s done, %0d failures", name, n_fail - fails_before);
	endtask

	initial begin
		int   f0;
		adr_t a;
		void'($urandom(32'hc366f876));
		arst_n_i = 1'b0;
		req      = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		arst_n_i = 1'b1;

		f0 = n_fail;
		repeat (20) begin
			@(negedge clk);
			expect_value("idle ack", 64'd0, {63'b0, rsp.ack});
			expect_value("idle err", 64'd0, {63'b0, rsp.err});
		end
		end_test("reset_idle", f0);

		f0 = n_fail;
		for (int i = 0; i < 32; i++) begin
			a = ram_adr(i);
			bus_write("ram fill", 8'hff, a, {a ^ 32'h5a5a_0f0f, ~a});
		end
		for (int i = 0; i < 16; i++) begin
			a = ram_adr($urandom_range(0, 31));
			bus_write("ram write", sel8_t'($urandom), a, {$urandom, $urandom});
			bus_read("ram read", a);
		end
		end_test("ram_byte_lanes", f0);

		f0 = n_fail;
		for (int i = 0; i < 32; i++) begin
			a = text_adr(i);
			bus_write("text fill", 8'hff, a, {2{a ^ 32'h3c3c_a5a5}});
		end
		for (int i = 0; i < 16; i++) begin
			a = text_adr(i); // odd i sets bit 2
			bus_write("text write", sel8_t'($urandom), a, {$urandom, $urandom});
			bus_read("text read", a);
			bus_read("text neighbour", a ^ 32'h4);
		end
		end_test("text_half_select", f0);

		f0 = n_fail;
		for (int i = 0; i < 8; i++) begin
			a = {16'h1000 + 16'($urandom_range(0, 255)), 9'd0, 7'($urandom)};
			bus_write("unmapped write", 8'hff, a, 64'hdead_beef_dead_beef);
			bus_read("unmapped read", a);
			bus_read("ram reread", {`SOC_RAM_BASE_HI, a[15:0]});
			bus_read("text reread", {`SOC_TEXT_BASE_HI, a[15:0]});
		end
		end_test("unmapped_error", f0);

		f0 = n_fail;
		for (int i = 0; i < 200; i++) begin
			case ($urandom_range(0, 2))
				0: a = ram_adr($urandom_range(0, 31));
				1: a = text_adr($urandom_range(0, 31));
				default: a = {16'hff00, 16'($urandom)};
			endcase
			if ($urandom_range(0, 1) == 1) begin
				bus_write("random write", sel8_t'($urandom), a, {$urandom, $urandom});
			end else begin
				bus_read("random read", a);
			end
		end
		end_test("random_mix", f0);

		$display("checks passed %0d, failed %0d", n_pass, n_fail);
		if (n_fail == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

//--- files.f
+incdir+source
source/soc_bus_pkg.sv
source/bus_decoder.sv
source/bus_ram.sv
source/io_bridge.sv
source/text_mem.sv
source/soc_bus_top.sv
dv/soc_bus_tb.sv

//--- Bender.yml
package:
  name: soc_bus

sources:
  - include_dirs:
      - source
    files:
      - source/soc_bus_pkg.sv
      - source/bus_decoder.sv
      - source/bus_ram.sv
      - source/io_bridge.sv
      - source/text_mem.sv
      - source/soc_bus_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/soc_bus_tb.sv
